// File: rtl/rv_decoder_pkg.sv
package rv_decoder_pkg;

  //////////////////////////////////////////////////////////////////////
  // Field widths and encodings
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned INSTR_W  = 32;
  localparam int unsigned OPCODE_W = 7;
  localparam int unsigned FUNCT3_W = 3;
  localparam int unsigned FUNCT7_W = 7;
  localparam int unsigned IMM12_W  = 12;
  // rs2/rs1/rd share what is left of an R-type word
  localparam int unsigned REG_ADDR_W = (INSTR_W - FUNCT7_W - FUNCT3_W - OPCODE_W) / 3;

  // Major opcodes, RV32I base
  localparam logic [OPCODE_W-1:0] OPCODE_JAL    = 7'h6f;
  localparam logic [OPCODE_W-1:0] OPCODE_JALR   = 7'h67;
  localparam logic [OPCODE_W-1:0] OPCODE_BRANCH = 7'h63;
  localparam logic [OPCODE_W-1:0] OPCODE_LOAD   = 7'h03;
  localparam logic [OPCODE_W-1:0] OPCODE_STORE  = 7'h23;
  localparam logic [OPCODE_W-1:0] OPCODE_LUI    = 7'h37;
  localparam logic [OPCODE_W-1:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [OPCODE_W-1:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'h33;
  localparam logic [OPCODE_W-1:0] OPCODE_SYSTEM = 7'h73;

  // SYSTEM imm12 with funct3 zero
  localparam logic [IMM12_W-1:0] SYS_ECALL  = 12'h000;
  localparam logic [IMM12_W-1:0] SYS_EBREAK = 12'h001;
  localparam logic [IMM12_W-1:0] SYS_MRET   = 12'h302;
  localparam logic [IMM12_W-1:0] SYS_WFI    = 12'h105;

  //////////////////////////////////////////////////////////////////////
  // Control enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00, ALU_SUB  = 5'h01, ALU_XOR  = 5'h02, ALU_OR   = 5'h03,
    ALU_AND  = 5'h04, ALU_SLL  = 5'h05, ALU_SRL  = 5'h06, ALU_SRA  = 5'h07,
    ALU_SLTS = 5'h08, ALU_SLTU = 5'h09, ALU_EQ   = 5'h0a, ALU_NE   = 5'h0b,
    ALU_LTS  = 5'h0c, ALU_GES  = 5'h0d, ALU_LTU  = 5'h0e, ALU_GEU  = 5'h0f
  } alu_op_e;

  typedef enum logic [2:0] {OP_A_REG = 3'b000, OP_A_CURRPC = 3'b001, OP_A_IMM = 3'b010} op_a_sel_e;
  typedef enum logic [2:0] {OP_B_REG = 3'b000, OP_B_IMM = 3'b010} op_b_sel_e;
  typedef enum logic {IMMA_Z = 1'b0, IMMA_ZERO = 1'b1} imm_a_sel_e; // Z is rs1 field zext

  typedef enum logic [3:0] {
    IMMB_I      = 4'b0000,
    IMMB_S      = 4'b0001,
    IMMB_U      = 4'b0010,
    IMMB_PCINCR = 4'b0011,
    IMMB_UJ     = 4'b1100,
    IMMB_SB     = 4'b1101
  } imm_b_sel_e;

  typedef enum logic [1:0] {DT_WORD = 2'd0, DT_HALF = 2'd1, DT_BYTE = 2'd2} data_type_e;
  typedef enum logic [1:0] {
    CSR_OP_NONE = 2'd0, CSR_OP_WRITE = 2'd1, CSR_OP_SET = 2'd2, CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  //////////////////////////////////////////////////////////////////////
  // Control bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
  } alu_ctrl_t;

  typedef struct packed {
    logic       req;       // Data memory request
    logic       we;        // Store strobe
    data_type_e data_type;
    logic       sign_ext;  // Loads only
  } lsu_ctrl_t;

  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebrk;
    logic mret;
    logic pipe_flush;  // WFI
  } sys_flags_t;

  typedef struct packed {
    alu_ctrl_t  alu;
    lsu_ctrl_t  lsu;
    logic       regfile_we;
    logic       csr_access;
    csr_op_e    csr_op;
    logic       jump;
    logic       branch;
    sys_flags_t flags;
  } dec_ctrl_t;

  // Idle bundle, every sub-decoder starts here
  localparam dec_ctrl_t DEC_DEFAULT = '{
    alu: '{alu_op: ALU_SLTU, op_a_sel: OP_A_REG, op_b_sel: OP_B_REG,
           imm_a_sel: IMMA_ZERO, imm_b_sel: IMMB_I},
    lsu: '{req: 1'b0, we: 1'b0, data_type: DT_WORD, sign_ext: 1'b0},
    regfile_we: 1'b0, csr_access: 1'b0, csr_op: CSR_OP_NONE,
    jump: 1'b0, branch: 1'b0,
    flags: '{illegal: 1'b0, ecall: 1'b0, ebrk: 1'b0, mret: 1'b0, pipe_flush: 1'b0}
  };

  //////////////////////////////////////////////////////////////////////
  // Instruction word, R view and I view
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [FUNCT3_W-1:0]   funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [OPCODE_W-1:0]   opcode;
  } instr_r_t;

  typedef struct packed {
    logic [IMM12_W-1:0]    imm12;  // Immediate, CSR address or system function
    logic [REG_ADDR_W-1:0] rs1;
    logic [FUNCT3_W-1:0]   funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [OPCODE_W-1:0]   opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// File: rtl/ctrl_xfer_decoder.sv
`timescale 1ns/1ns

module ctrl_xfer_decoder import rv_decoder_pkg::*; (
  input  instr_u    instr_i,
  input  logic      jump_set_i,    // Second phase of a jump, target calc
  input  logic      branch_set_i,  // Branch taken, target calc
  output dec_ctrl_t xfer_ctrl_o
);

  logic is_jump;  // JAL or JALR, bit 2 of the opcode
  logic is_jal;   // Bit 3 only set for JAL

  assign is_jump = instr_i.r.opcode[2];
  assign is_jal  = instr_i.r.opcode[3];

  always_comb begin
    xfer_ctrl_o = DEC_DEFAULT;

    if (is_jump) begin
      xfer_ctrl_o.jump          = 1'b1;
      xfer_ctrl_o.alu.alu_op    = ALU_ADD;
      xfer_ctrl_o.alu.op_b_sel  = OP_B_IMM;
      if (jump_set_i) begin
        // Target, PC + UJ or rs1 + I
        xfer_ctrl_o.alu.op_a_sel  = is_jal ? OP_A_CURRPC : OP_A_REG;
        xfer_ctrl_o.alu.imm_b_sel = is_jal ? IMMB_UJ : IMMB_I;
      end else begin
        // Link value PC + 4 into rd
        xfer_ctrl_o.alu.op_a_sel  = OP_A_CURRPC;
        xfer_ctrl_o.alu.imm_b_sel = IMMB_PCINCR;
        xfer_ctrl_o.regfile_we    = 1'b1;
      end
      if (!is_jal && instr_i.r.funct3 != '0) begin  // JALR needs funct3 zero
        xfer_ctrl_o.jump          = 1'b0;
        xfer_ctrl_o.regfile_we    = 1'b0;
        xfer_ctrl_o.flags.illegal = 1'b1;
      end
    end else begin
      xfer_ctrl_o.branch = 1'b1;
      if (!branch_set_i) begin
        // Compare phase
        unique case (instr_i.r.funct3)
          3'b000:  xfer_ctrl_o.alu.alu_op = ALU_EQ;
          3'b001:  xfer_ctrl_o.alu.alu_op = ALU_NE;
          3'b100:  xfer_ctrl_o.alu.alu_op = ALU_LTS;
          3'b101:  xfer_ctrl_o.alu.alu_op = ALU_GES;
          3'b110:  xfer_ctrl_o.alu.alu_op = ALU_LTU;
          3'b111:  xfer_ctrl_o.alu.alu_op = ALU_GEU;
          default: xfer_ctrl_o.flags.illegal = 1'b1;  // 010, 011
        endcase
      end else begin
        xfer_ctrl_o.alu.alu_op    = ALU_ADD;  // PC + SB offset
        xfer_ctrl_o.alu.op_a_sel  = OP_A_CURRPC;
        xfer_ctrl_o.alu.op_b_sel  = OP_B_IMM;
        xfer_ctrl_o.alu.imm_b_sel = IMMB_SB;
      end
    end
  end

endmodule

// File: rtl/mem_access_decoder.sv
`timescale 1ns/1ns

module mem_access_decoder import rv_decoder_pkg::*; (
  input  instr_u    instr_i,
  output dec_ctrl_t mem_ctrl_o
);

  logic       is_store;  // Opcode bit 5
  data_type_e size;      // From funct3[1:0]

  assign is_store = instr_i.r.opcode[5];

  // Access size, shared by loads and stores
  always_comb begin
    unique case (instr_i.r.funct3[1:0])
      2'b00:   size = DT_BYTE;
      2'b01:   size = DT_HALF;
      default: size = DT_WORD;  // 11 flagged below
    endcase
  end

  always_comb begin
    mem_ctrl_o                = DEC_DEFAULT;
    mem_ctrl_o.lsu.req        = 1'b1;
    mem_ctrl_o.lsu.data_type  = size;
    mem_ctrl_o.alu.alu_op     = ALU_ADD;  // Address is rs1 + offset
    mem_ctrl_o.alu.op_b_sel   = OP_B_IMM;

    if (is_store) begin
      mem_ctrl_o.lsu.we        = 1'b1;
      mem_ctrl_o.alu.imm_b_sel = IMMB_S;
      // No reg-reg stores and no size 3
      if (instr_i.r.funct3[2] || instr_i.r.funct3[1:0] == 2'b11) begin
        mem_ctrl_o.lsu.req        = 1'b0;
        mem_ctrl_o.lsu.we         = 1'b0;
        mem_ctrl_o.flags.illegal  = 1'b1;
      end
    end else begin
      mem_ctrl_o.regfile_we    = 1'b1;
      mem_ctrl_o.alu.imm_b_sel = IMMB_I;
      mem_ctrl_o.lsu.sign_ext  = ~instr_i.r.funct3[2];  // LBU/LHU zero extend
      // LD is RV64, 110 and 111 unused
      if (instr_i.r.funct3 == 3'b011 || instr_i.r.funct3[2:1] == 2'b11) begin
        mem_ctrl_o.flags.illegal = 1'b1;
      end
    end
  end

endmodule

// File: rtl/int_alu_decoder.sv
`timescale 1ns/1ns

module int_alu_decoder import rv_decoder_pkg::*; (
  input  instr_u    instr_i,
  output dec_ctrl_t alu_ctrl_o
);

  logic [FUNCT7_W-1:0] funct7;
  logic [FUNCT3_W-1:0] funct3;

  assign funct7 = instr_i.r.funct7;
  assign funct3 = instr_i.r.funct3;

  always_comb begin
    alu_ctrl_o            = DEC_DEFAULT;
    alu_ctrl_o.regfile_we = 1'b1;  // All four write rd

    unique case ({instr_i.r.opcode[5], instr_i.r.opcode[2]})
      2'b11: begin  // LUI, 0 + U
        alu_ctrl_o.alu.alu_op    = ALU_ADD;
        alu_ctrl_o.alu.op_a_sel  = OP_A_IMM;
        alu_ctrl_o.alu.imm_a_sel = IMMA_ZERO;
        alu_ctrl_o.alu.op_b_sel  = OP_B_IMM;
        alu_ctrl_o.alu.imm_b_sel = IMMB_U;
      end

      2'b01: begin  // AUIPC, PC + U
        alu_ctrl_o.alu.alu_op    = ALU_ADD;
        alu_ctrl_o.alu.op_a_sel  = OP_A_CURRPC;
        alu_ctrl_o.alu.op_b_sel  = OP_B_IMM;
        alu_ctrl_o.alu.imm_b_sel = IMMB_U;
      end

      2'b00: begin  // OP-IMM
        alu_ctrl_o.alu.op_b_sel  = OP_B_IMM;
        alu_ctrl_o.alu.imm_b_sel = IMMB_I;
        unique case (funct3)
          3'b000: alu_ctrl_o.alu.alu_op = ALU_ADD;
          3'b010: alu_ctrl_o.alu.alu_op = ALU_SLTS;
          3'b011: alu_ctrl_o.alu.alu_op = ALU_SLTU;
          3'b100: alu_ctrl_o.alu.alu_op = ALU_XOR;
          3'b110: alu_ctrl_o.alu.alu_op = ALU_OR;
          3'b111: alu_ctrl_o.alu.alu_op = ALU_AND;
          3'b001: begin
            alu_ctrl_o.alu.alu_op = ALU_SLL;
            if (funct7 != '0) alu_ctrl_o.flags.illegal = 1'b1;  // shamt[5] set
          end
          default: begin  // 101, SRLI or SRAI
            if (funct7 == 7'b000_0000)      alu_ctrl_o.alu.alu_op = ALU_SRL;
            else if (funct7 == 7'b010_0000) alu_ctrl_o.alu.alu_op = ALU_SRA;
            else                            alu_ctrl_o.flags.illegal = 1'b1;
          end
        endcase
      end

      default: begin  // OP, reg-reg
        // Bit 31 or bit 28 would be bit-manip encodings
        if (funct7[6] || funct7[3]) begin
          alu_ctrl_o.flags.illegal = 1'b1;
        end else begin
          unique case ({funct7[5:0], funct3})
            {6'b00_0000, 3'b000}: alu_ctrl_o.alu.alu_op = ALU_ADD;
            {6'b10_0000, 3'b000}: alu_ctrl_o.alu.alu_op = ALU_SUB;
            {6'b00_0000, 3'b001}: alu_ctrl_o.alu.alu_op = ALU_SLL;
            {6'b00_0000, 3'b010}: alu_ctrl_o.alu.alu_op = ALU_SLTS;
            {6'b00_0000, 3'b011}: alu_ctrl_o.alu.alu_op = ALU_SLTU;
            {6'b00_0000, 3'b100}: alu_ctrl_o.alu.alu_op = ALU_XOR;
            {6'b00_0000, 3'b101}: alu_ctrl_o.alu.alu_op = ALU_SRL;
            {6'b10_0000, 3'b101}: alu_ctrl_o.alu.alu_op = ALU_SRA;
            {6'b00_0000, 3'b110}: alu_ctrl_o.alu.alu_op = ALU_OR;
            {6'b00_0000, 3'b111}: alu_ctrl_o.alu.alu_op = ALU_AND;
            default:              alu_ctrl_o.flags.illegal = 1'b1;
          endcase
        end
      end
    endcase
  end

endmodule

// File: rtl/system_decoder.sv
`timescale 1ns/1ns

module system_decoder import rv_decoder_pkg::*; (
  input  instr_u    instr_i,
  output dec_ctrl_t sys_ctrl_o
);

  logic is_priv;  // funct3 zero, no CSR access

  assign is_priv = (instr_i.i.funct3 == '0);

  always_comb begin
    sys_ctrl_o = DEC_DEFAULT;

    if (is_priv) begin
      // imm12 of the I view picks the function
      unique case (instr_i.i.imm12)
        SYS_ECALL:  sys_ctrl_o.flags.ecall      = 1'b1;  // Environment call
        SYS_EBREAK: sys_ctrl_o.flags.ebrk       = 1'b1;  // Debug trap
        SYS_MRET:   sys_ctrl_o.flags.mret       = 1'b1;
        SYS_WFI:    sys_ctrl_o.flags.pipe_flush = 1'b1;  // Sleep after flush
        default:    sys_ctrl_o.flags.illegal    = 1'b1;
      endcase
    end else begin
      //////////////////////////////////////////////////////////////////
      // CSR read-modify-write
      //////////////////////////////////////////////////////////////////
      sys_ctrl_o.csr_access    = 1'b1;
      sys_ctrl_o.regfile_we    = 1'b1;  // Old CSR value to rd
      sys_ctrl_o.alu.op_b_sel  = OP_B_IMM;
      sys_ctrl_o.alu.imm_a_sel = IMMA_Z;
      sys_ctrl_o.alu.imm_b_sel = IMMB_I;  // CSR address sits in imm12

      // Immediate forms use rs1 as a 5-bit zimm
      if (instr_i.i.funct3[2]) begin
        sys_ctrl_o.alu.op_a_sel = OP_A_IMM;
      end else begin
        sys_ctrl_o.alu.op_a_sel = OP_A_REG;
      end

      unique case (instr_i.i.funct3[1:0])
        2'b01:   sys_ctrl_o.csr_op = CSR_OP_WRITE;
        2'b10:   sys_ctrl_o.csr_op = CSR_OP_SET;
        2'b11:   sys_ctrl_o.csr_op = CSR_OP_CLEAR;
        default: sys_ctrl_o.flags.illegal = 1'b1;  // funct3 100
      endcase
    end
  end

endmodule

// File: rtl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder import rv_decoder_pkg::*; (
  // From IF/ID
  input  instr_u     instr_rdata_i,
  input  logic       illegal_c_insn_i,   // Compressed expander rejected it
  // From controller
  input  logic       deassert_we_i,      // Stalled or not active
  input  logic       data_misaligned_i,  // Second half of a split access
  input  logic       jump_set_i,
  input  logic       branch_set_i,
  // Decoded control
  output alu_ctrl_t  alu_ctrl_o,
  output lsu_ctrl_t  lsu_ctrl_o,
  output logic       regfile_we_o,
  output logic       csr_access_o,
  output csr_op_e    csr_op_o,
  output logic       jump_in_id_o,
  output logic       branch_in_id_o,
  output sys_flags_t sys_flags_o
);

  dec_ctrl_t xfer_ctrl, mem_ctrl, ialu_ctrl, sys_ctrl;
  dec_ctrl_t dec_ctrl;   // After opcode select and overrides
  dec_ctrl_t out_ctrl;   // After stall gating

  ctrl_xfer_decoder  u_xfer (.instr_i(instr_rdata_i), .jump_set_i, .branch_set_i,
                             .xfer_ctrl_o(xfer_ctrl));
  mem_access_decoder u_mem  (.instr_i(instr_rdata_i), .mem_ctrl_o(mem_ctrl));
  int_alu_decoder    u_ialu (.instr_i(instr_rdata_i), .alu_ctrl_o(ialu_ctrl));
  system_decoder     u_sys  (.instr_i(instr_rdata_i), .sys_ctrl_o(sys_ctrl));

  //////////////////////////////////////////////////////////////////////
  // Opcode select, then illegal and misaligned rules
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (instr_rdata_i.r.opcode)
      OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH:             dec_ctrl = xfer_ctrl;
      OPCODE_LOAD, OPCODE_STORE:                          dec_ctrl = mem_ctrl;
      OPCODE_LUI, OPCODE_AUIPC, OPCODE_OPIMM, OPCODE_OP:  dec_ctrl = ialu_ctrl;
      OPCODE_SYSTEM:                                      dec_ctrl = sys_ctrl;
      default: begin
        dec_ctrl               = DEC_DEFAULT;
        dec_ctrl.flags.illegal = 1'b1;  // Unknown major opcode
      end
    endcase

    if (illegal_c_insn_i) begin
      dec_ctrl.flags.illegal = 1'b1;
    end

    // Only the AGU part of the pipe runs again, so steer rs1 + 4
    // and keep the first address write-back as the only one
    if (data_misaligned_i) begin
      dec_ctrl.alu.op_a_sel  = OP_A_REG;
      dec_ctrl.alu.op_b_sel  = OP_B_IMM;
      dec_ctrl.alu.imm_b_sel = IMMB_PCINCR;
      dec_ctrl.regfile_we    = 1'b0;
    end
  end

  // Stall gating of side effects, trap info still flows
  always_comb begin
    out_ctrl = dec_ctrl;
    if (deassert_we_i) begin
      out_ctrl.regfile_we       = 1'b0;
      out_ctrl.lsu.req          = 1'b0;
      out_ctrl.jump             = 1'b0;
      out_ctrl.branch           = 1'b0;
      out_ctrl.csr_op           = CSR_OP_NONE;
      out_ctrl.flags.ebrk       = 1'b0;
      out_ctrl.flags.mret       = 1'b0;
      out_ctrl.flags.pipe_flush = 1'b0;
    end
  end

  assign alu_ctrl_o     = out_ctrl.alu;
  assign lsu_ctrl_o     = out_ctrl.lsu;
  assign regfile_we_o   = out_ctrl.regfile_we;
  assign csr_access_o   = out_ctrl.csr_access;
  assign csr_op_o       = out_ctrl.csr_op;
  assign jump_in_id_o   = out_ctrl.jump;
  assign branch_in_id_o = out_ctrl.branch;
  assign sys_flags_o    = out_ctrl.flags;

endmodule

// File: dv/rv_decoder_tb.sv
`timescale 1ns/1ns

module rv_decoder_tb import rv_decoder_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 1000;  // 5 tests of up to 60 vectors plus margin

  logic       clk;
  logic       reset_i;
  instr_u     instr_rdata_i;
  logic       illegal_c_insn_i, deassert_we_i, data_misaligned_i, jump_set_i, branch_set_i;
  alu_ctrl_t  alu_ctrl_o;
  lsu_ctrl_t  lsu_ctrl_o;
  logic       regfile_we_o, csr_access_o, jump_in_id_o, branch_in_id_o;
  csr_op_e    csr_op_o;
  sys_flags_t sys_flags_o;

  int seed = 32'h1c55;
  int errors, tests_passed, tests_failed;
  int cycle_cnt;  // Run length guard

  rv_decoder uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset_i) begin
      cycle_cnt <= 0;
    end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_alu(input alu_ctrl_t got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s alu_ctrl %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_lsu(input lsu_ctrl_t got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s lsu_ctrl %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_flags(input sys_flags_t got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s sys_flags %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_csr(input csr_op_e got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s csr_op %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Register fields random
  function automatic instr_u mk_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
    return {f7, 5'(rnd()), 5'(rnd()), f3, 5'(rnd()), opc};
  endfunction

  function automatic instr_u mk_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
    return {imm, 5'(rnd()), f3, 5'(rnd()), opc};
  endfunction

  // Idle bundle with ALU selects and rd write
  function automatic dec_ctrl_t exp_alu(alu_op_e op, op_a_sel_e a, op_b_sel_e b,
                                        imm_b_sel_e ib, logic we);
    dec_ctrl_t e;
    e            = DEC_DEFAULT;
    e.alu        = '{op, a, b, IMMA_ZERO, ib};
    e.regfile_we = we;
    return e;
  endfunction

  // ctl is {jump_set, branch_set, c_illegal, misaligned, deassert_we}
  task automatic drive(input instr_u ins, input logic [4:0] ctl);
    @(posedge clk);
    instr_rdata_i <= ins;
    {jump_set_i, branch_set_i, illegal_c_insn_i, data_misaligned_i, deassert_we_i} <= ctl;
    @(negedge clk);  // Comb outputs settled
  endtask

  task automatic vec(input instr_u ins, input logic [4:0] ctl, input dec_ctrl_t exp,
                     input string msg);
    drive(ins, ctl);
    check_alu(alu_ctrl_o, exp.alu, msg);
    check_lsu(lsu_ctrl_o, exp.lsu, msg);
    check_bit(regfile_we_o, exp.regfile_we, {msg, " regfile_we"});
    check_bit(csr_access_o, exp.csr_access, {msg, " csr_access"});
    check_csr(csr_op_o, exp.csr_op, msg);
    check_bit(jump_in_id_o, exp.jump, {msg, " jump"});
    check_bit(branch_in_id_o, exp.branch, {msg, " branch"});
    check_flags(sys_flags_o, exp.flags, msg);
  endtask

  task automatic vec_illegal(input instr_u ins, input logic [4:0] ctl, input string msg);
    drive(ins, ctl);
    check_bit(sys_flags_o.illegal, 1'b1, {msg, " illegal"});
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %-9s ok", name);
    end else begin
      tests_failed++;
      $display("test %-9s failed, %0d mismatches", name, errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_int_alu();
    int        e0;
    dec_ctrl_t exp;
    instr_u    ins;
    alu_op_e   ops[8];
    e0  = errors;
    ops = '{ALU_ADD, ALU_SLL, ALU_SLTS, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    for (int f = 0; f < 8; f++) begin  // Same funct3 order in OP-IMM and OP
      exp = exp_alu(ops[f], OP_A_REG, OP_B_IMM, IMMB_I, 1'b1);
      vec(mk_i({7'h00, 5'(rnd())}, 3'(f), OPCODE_OPIMM), 5'b0, exp,
          $sformatf("opimm f3=%0d", f));
      exp.alu.op_b_sel = OP_B_REG;
      vec(mk_r(7'h00, 3'(f), OPCODE_OP), 5'b0, exp, $sformatf("op f3=%0d", f));
    end
    exp = exp_alu(ALU_SRA, OP_A_REG, OP_B_IMM, IMMB_I, 1'b1);
    vec(mk_i({7'h20, 5'(rnd())}, 3'd5, OPCODE_OPIMM), 5'b0, exp, "srai");
    exp.alu.op_b_sel = OP_B_REG;
    vec(mk_r(7'h20, 3'd5, OPCODE_OP), 5'b0, exp, "sra");
    exp.alu.alu_op = ALU_SUB;
    vec(mk_r(7'h20, 3'd0, OPCODE_OP), 5'b0, exp, "sub");
    vec_illegal(mk_i({7'h20, 5'(rnd())}, 3'd1, OPCODE_OPIMM), 5'b0, "slli bad funct7");
    vec_illegal(mk_i({7'h01, 5'(rnd())}, 3'd5, OPCODE_OPIMM), 5'b0, "srli bad funct7");
    vec_illegal(mk_r(7'h40, 3'd0, OPCODE_OP), 5'b0, "op bit 31");
    vec_illegal(mk_r(7'h08, 3'd1, OPCODE_OP), 5'b0, "op bit 28");
    ins          = rnd();
    ins.r.opcode = OPCODE_LUI;
    vec(ins, 5'b0, exp_alu(ALU_ADD, OP_A_IMM, OP_B_IMM, IMMB_U, 1'b1), "lui");
    ins.r.opcode = OPCODE_AUIPC;
    vec(ins, 5'b0, exp_alu(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_U, 1'b1), "auipc");
    finish_test("int_alu", e0);
  endtask

  task automatic test_mem();
    int         e0;
    dec_ctrl_t  exp;
    logic [2:0] f3s[5];
    data_type_e dts[5];
    e0  = errors;
    f3s = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};  // LB LH LW LBU LHU
    dts = '{DT_BYTE, DT_HALF, DT_WORD, DT_BYTE, DT_HALF};
    for (int k = 0; k < 5; k++) begin
      exp     = exp_alu(ALU_ADD, OP_A_REG, OP_B_IMM, IMMB_I, 1'b1);
      exp.lsu = '{1'b1, 1'b0, dts[k], k < 3};  // Only LBU/LHU zero extend
      vec(mk_i(12'(rnd()), f3s[k], OPCODE_LOAD), 5'b0, exp, $sformatf("load f3=%0d", f3s[k]));
      if (k < 3) begin  // SB SH SW
        exp     = exp_alu(ALU_ADD, OP_A_REG, OP_B_IMM, IMMB_S, 1'b0);
        exp.lsu = '{1'b1, 1'b1, dts[k], 1'b0};
        vec(mk_r(7'(rnd()), f3s[k], OPCODE_STORE), 5'b0, exp,
            $sformatf("store f3=%0d", f3s[k]));
      end
    end
    vec_illegal(mk_r(7'(rnd()), 3'd4, OPCODE_STORE), 5'b0, "store f3=4");
    check_bit(lsu_ctrl_o.req, 1'b0, "bad store req");
    vec_illegal(mk_i(12'(rnd()), 3'd3, OPCODE_LOAD), 5'b0, "load f3=3");
    vec_illegal(mk_i(12'(rnd()), 3'd6, OPCODE_LOAD), 5'b0, "load f3=6");
    vec_illegal(mk_i(12'(rnd()), 3'd7, OPCODE_LOAD), 5'b0, "load f3=7");
    finish_test("mem", e0);
  endtask

  task automatic test_xfer();
    int         e0;
    dec_ctrl_t  exp;
    instr_u     ins;
    logic [2:0] f3s[6];
    alu_op_e    ops[6];
    e0           = errors;
    ins          = rnd();
    ins.r.opcode = OPCODE_JAL;
    exp          = exp_alu(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b1);
    exp.jump     = 1'b1;
    vec(ins, 5'b00000, exp, "jal link");  // First phase writes PC + 4
    ins = mk_i(12'(rnd()), 3'd0, OPCODE_JALR);
    vec(ins, 5'b00000, exp, "jalr link");
    exp.regfile_we    = 1'b0;
    exp.alu.op_a_sel  = OP_A_REG;
    exp.alu.imm_b_sel = IMMB_I;
    vec(ins, 5'b10000, exp, "jalr target");
    ins               = rnd();
    ins.r.opcode      = OPCODE_JAL;
    exp.alu.op_a_sel  = OP_A_CURRPC;
    exp.alu.imm_b_sel = IMMB_UJ;
    vec(ins, 5'b10000, exp, "jal target");
    vec_illegal(mk_i(12'(rnd()), 3'd2, OPCODE_JALR), 5'b00000, "jalr f3=2");
    check_bit(jump_in_id_o, 1'b0, "bad jalr jump");
    check_bit(regfile_we_o, 1'b0, "bad jalr regfile_we");
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ops = '{ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU};
    for (int k = 0; k < 6; k++) begin
      ins        = mk_r(7'(rnd()), f3s[k], OPCODE_BRANCH);
      exp        = exp_alu(ops[k], OP_A_REG, OP_B_REG, IMMB_I, 1'b0);
      exp.branch = 1'b1;
      vec(ins, 5'b00000, exp, $sformatf("branch cmp f3=%0d", f3s[k]));
      exp.alu = '{ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMA_ZERO, IMMB_SB};  // Target phase
      vec(ins, 5'b01000, exp, $sformatf("branch target f3=%0d", f3s[k]));
    end
    vec_illegal(mk_r(7'(rnd()), 3'd2, OPCODE_BRANCH), 5'b0, "branch f3=2");
    vec_illegal(mk_r(7'(rnd()), 3'd3, OPCODE_BRANCH), 5'b0, "branch f3=3");
    finish_test("xfer", e0);
  endtask

  task automatic test_system();
    int          e0;
    dec_ctrl_t   exp;
    logic [11:0] funcs[4];
    csr_op_e     csr_ops[4];
    e0    = errors;
    funcs = '{12'h000, 12'h001, 12'h302, 12'h105};  // ECALL EBREAK MRET WFI
    for (int k = 0; k < 4; k++) begin
      exp       = DEC_DEFAULT;
      exp.flags = sys_flags_t'(5'b01000 >> k);  // One flag each
      vec({funcs[k], 5'd0, 3'd0, 5'd0, OPCODE_SYSTEM}, 5'b0, exp,
          $sformatf("system %h", funcs[k]));
    end
    vec_illegal(mk_i(12'h7ff, 3'd0, OPCODE_SYSTEM), 5'b0, "system unknown imm12");
    csr_ops = '{CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR};
    for (int f = 1; f < 8; f++) begin
      if (f != 4) begin
        exp = exp_alu(ALU_SLTU, (f > 4) ? OP_A_IMM : OP_A_REG, OP_B_IMM, IMMB_I, 1'b1);
        exp.alu.imm_a_sel = IMMA_Z;
        exp.csr_access    = 1'b1;
        exp.csr_op        = csr_ops[f % 4];
        vec(mk_i(12'(rnd()), 3'(f), OPCODE_SYSTEM), 5'b0, exp, $sformatf("csr f3=%0d", f));
      end
    end
    vec_illegal(mk_i(12'(rnd()), 3'd4, OPCODE_SYSTEM), 5'b0, "csr f3=4");
    finish_test("system", e0);
  endtask

  task automatic test_override();
    int        e0;
    dec_ctrl_t exp;
    instr_u    ins;
    e0                = errors;
    exp               = DEC_DEFAULT;
    exp.flags.illegal = 1'b1;
    ins               = mk_r(7'(rnd()), 3'(rnd()), 7'h0b);  // Custom-0 opcode is not decoded
    vec(ins, 5'b00000, exp, "unknown opcode");
    vec(ins, 5'b00001, exp, "stalled unknown opcode");  // illegal survives the stall
    exp               = exp_alu(ALU_ADD, OP_A_REG, OP_B_REG, IMMB_I, 1'b1);
    exp.flags.illegal = 1'b1;
    vec(mk_r(7'h00, 3'd0, OPCODE_OP), 5'b00100, exp, "compressed illegal");
    exp          = exp_alu(ALU_ADD, OP_A_REG, OP_B_IMM, IMMB_PCINCR, 1'b0);
    ins          = rnd();
    ins.r.opcode = OPCODE_AUIPC;
    vec(ins, 5'b00010, exp, "misaligned auipc");  // PC operand forced back to rs1
    vec(mk_r(7'h00, 3'd0, OPCODE_OP), 5'b00010, exp, "misaligned add");  // rs2 swapped for 4
    exp.lsu = '{1'b1, 1'b0, DT_WORD, 1'b1};
    vec(mk_i(12'(rnd()), 3'd2, OPCODE_LOAD), 5'b00010, exp, "misaligned lw");
    exp.alu.imm_b_sel = IMMB_I;
    exp.lsu.req       = 1'b0;
    vec(mk_i(12'(rnd()), 3'd2, OPCODE_LOAD), 5'b00001, exp, "stalled lw");
    exp = exp_alu(ALU_SLTU, OP_A_REG, OP_B_IMM, IMMB_I, 1'b0);
    exp.alu.imm_a_sel = IMMA_Z;
    exp.csr_access    = 1'b1;  // Access stays while the operation is gated
    vec(mk_i(12'(rnd()), 3'd1, OPCODE_SYSTEM), 5'b00001, exp, "stalled csrrw");
    ins          = rnd();
    ins.r.opcode = OPCODE_JAL;
    vec(ins, 5'b00001, exp_alu(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b0),
        "stalled jal");
    vec(mk_r(7'(rnd()), 3'd0, OPCODE_BRANCH), 5'b00001,
        exp_alu(ALU_EQ, OP_A_REG, OP_B_REG, IMMB_I, 1'b0), "stalled beq");
    ins = {12'h001, 5'd0, 3'd0, 5'd0, OPCODE_SYSTEM};
    vec(ins, 5'b00001, DEC_DEFAULT, "stalled ebreak");
    ins.i.imm12 = 12'h302;
    vec(ins, 5'b00001, DEC_DEFAULT, "stalled mret");
    ins.i.imm12 = 12'h105;
    vec(ins, 5'b00001, DEC_DEFAULT, "stalled wfi");
    exp             = DEC_DEFAULT;
    exp.flags.ecall = 1'b1;
    ins.i.imm12     = 12'h000;
    vec(ins, 5'b00001, exp, "stalled ecall");
    finish_test("override", e0);
  endtask

  initial begin
    reset_i           = 1'b1;
    instr_rdata_i     = '0;
    illegal_c_insn_i  = 1'b0;
    deassert_we_i     = 1'b0;
    data_misaligned_i = 1'b0;
    jump_set_i        = 1'b0;
    branch_set_i      = 1'b0;
    errors            = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;

    test_int_alu();
    test_mem();
    test_xfer();
    test_system();
    test_override();

    $display("tests ok %0d, tests failed %0d, mismatches %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: rv_decoder.f
rtl/rv_decoder_pkg.sv
rtl/ctrl_xfer_decoder.sv
rtl/mem_access_decoder.sv
rtl/int_alu_decoder.sv
rtl/system_decoder.sv
rtl/rv_decoder.sv
dv/rv_decoder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=rv_decoder_sim
log_file=sim.log

verilator --binary --timing -f rv_decoder.f --top-module rv_decoder_tb \
  -Mdir "$obj_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$obj_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$log_file"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail, see $log_file"
  exit 1
fi
